// File: src/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int ALU_OP_W   = 3;

  // ----------------------------------------
  // alu operation codes
  // ----------------------------------------
  localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
  localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
  localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
  localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'd4;

  // major opcodes of the supported subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // one instruction word seen as R-type or I-type
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } r;
    struct packed {
      logic [11:0]           imm;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } i;
  } instr_t;

endpackage

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import core_pkg::*; (
  input  wire logic [ALU_OP_W-1:0] op_i,
  input  wire logic [XLEN-1:0]     a_i,
  input  wire logic [XLEN-1:0]     b_i,
  output logic [XLEN-1:0]          result_o
);

  // sums wrap at the word width
  always_comb begin
    case (op_i)
      ALU_ADD: result_o = a_i + b_i;
      ALU_SUB: result_o = a_i - b_i;
      ALU_AND: result_o = a_i & b_i;
      ALU_OR:  result_o = a_i | b_i;
      ALU_XOR: result_o = a_i ^ b_i;
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile import core_pkg::*; (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic [REG_ADDR_W-1:0] raddr_a_i,
  input  wire logic [REG_ADDR_W-1:0] raddr_b_i,
  output logic [XLEN-1:0]            rdata_a_o,
  output logic [XLEN-1:0]            rdata_b_o,
  input  wire logic                  we_i,
  input  wire logic [REG_ADDR_W-1:0] waddr_i,
  input  wire logic [XLEN-1:0]       wdata_i
);

  // x1..x31, x0 has no storage
  logic [XLEN-1:0] regs_q [1:31];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

  // commit filters rd 0 out of the write enable
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    we_i |-> waddr_i != '0);

endmodule

`default_nettype wire

// File: src/id_stage.sv
`timescale 1ns/100ps
`default_nettype none

module id_stage import core_pkg::*; (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  instr_valid_i,
  output logic                       instr_ready_o,
  input  wire logic [31:0]           instr_i,
  output logic                       dec_valid_o,
  input  wire logic                  dec_ready_i,
  output logic [REG_ADDR_W-1:0]      rs1_o,
  output logic [REG_ADDR_W-1:0]      rs2_o,
  output logic [REG_ADDR_W-1:0]      rd_o,
  output logic [XLEN-1:0]            imm_o,
  output logic                       use_imm_o,
  output logic [ALU_OP_W-1:0]        alu_op_o,
  output logic                       illegal_o,
  output logic [31:0]                tval_o
);

  logic                  instr_valid_q;
  instr_t                instr_q;
  logic                  out_ready;
  logic                  move;
  logic [REG_ADDR_W-1:0] rs1_d;
  logic [REG_ADDR_W-1:0] rs2_d;
  logic [REG_ADDR_W-1:0] rd_d;
  logic [XLEN-1:0]       imm_d;
  logic                  use_imm_d;
  logic [ALU_OP_W-1:0]   alu_op_d;
  logic                  illegal_d;

  // output slot frees up when empty or draining
  assign out_ready     = ~dec_valid_o | dec_ready_i;
  assign instr_ready_o = ~instr_valid_q | out_ready;
  assign move          = instr_valid_q & out_ready;

  // ----------------------------------------
  // decode
  // ----------------------------------------
  always_comb begin
    rs1_d     = instr_q.r.rs1;
    rs2_d     = '0;
    rd_d      = instr_q.r.rd;
    imm_d     = '0;
    use_imm_d = 1'b0;
    alu_op_d  = ALU_ADD;
    illegal_d = 1'b0;
    case (instr_q.r.opcode)
      OPC_OP: begin
        rs2_d = instr_q.r.rs2;
        if (instr_q.r.funct7 == F7_SUB && instr_q.r.funct3 == F3_ADD_SUB) begin
          alu_op_d = ALU_SUB;
        end else if (instr_q.r.funct7 != F7_BASE) begin
          illegal_d = 1'b1;
        end else begin
          case (instr_q.r.funct3)
            F3_ADD_SUB: alu_op_d = ALU_ADD;
            F3_XOR:     alu_op_d = ALU_XOR;
            F3_OR:      alu_op_d = ALU_OR;
            F3_AND:     alu_op_d = ALU_AND;
            default:    illegal_d = 1'b1;
          endcase
        end
      end
      OPC_OP_IMM: begin
        imm_d     = {{(XLEN-12){instr_q.i.imm[11]}}, instr_q.i.imm};
        use_imm_d = 1'b1;
        case (instr_q.i.funct3)
          F3_ADD_SUB: alu_op_d = ALU_ADD;
          F3_XOR:     alu_op_d = ALU_XOR;
          F3_OR:      alu_op_d = ALU_OR;
          F3_AND:     alu_op_d = ALU_AND;
          default:    illegal_d = 1'b1;
        endcase
      end
      default: illegal_d = 1'b1;
    endcase
    // an illegal word names no registers
    if (illegal_d) begin
      rs1_d = '0;
      rs2_d = '0;
      rd_d  = '0;
      imm_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_q <= 1'b0;
      dec_valid_o   <= 1'b0;
    end else begin
      if (instr_valid_i && instr_ready_o) begin
        instr_valid_q <= 1'b1;
      end else if (move) begin
        instr_valid_q <= 1'b0;
      end
      if (move) begin
        dec_valid_o <= 1'b1;
      end else if (dec_ready_i) begin
        dec_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i && instr_ready_o) begin
      instr_q <= instr_i;
    end
    if (move) begin
      rs1_o     <= rs1_d;
      rs2_o     <= rs2_d;
      rd_o      <= rd_d;
      imm_o     <= imm_d;
      use_imm_o <= use_imm_d;
      alu_op_o  <= alu_op_d;
      illegal_o <= illegal_d;
      tval_o    <= instr_q;
    end
  end

  // held item must not change while issue is blocked
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    dec_valid_o && !dec_ready_i |=> dec_valid_o &&
      $stable({rs1_o, rs2_o, rd_o, imm_o, use_imm_o, alu_op_o, illegal_o, tval_o}));

endmodule

`default_nettype wire

// File: src/issue_stage.sv
`timescale 1ns/100ps
`default_nettype none

module issue_stage import core_pkg::*; (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  dec_valid_i,
  output logic                       dec_ready_o,
  input  wire logic [REG_ADDR_W-1:0] rs1_i,
  input  wire logic [REG_ADDR_W-1:0] rs2_i,
  input  wire logic [REG_ADDR_W-1:0] rd_i,
  input  wire logic [XLEN-1:0]       imm_i,
  input  wire logic                  use_imm_i,
  input  wire logic [ALU_OP_W-1:0]   alu_op_i,
  input  wire logic                  illegal_i,
  input  wire logic [31:0]           tval_i,
  output logic                       iss_valid_o,
  input  wire logic                  iss_ready_i,
  output logic [REG_ADDR_W-1:0]      iss_rd_o,
  output logic [XLEN-1:0]            iss_result_o,
  output logic                       iss_illegal_o,
  output logic [31:0]                iss_tval_o,
  input  wire logic                  cm_valid_i,
  input  wire logic [REG_ADDR_W-1:0] cm_rd_i,
  input  wire logic [XLEN-1:0]       cm_result_i,
  input  wire logic                  wb_en_i,
  input  wire logic [REG_ADDR_W-1:0] wb_rd_i,
  input  wire logic [XLEN-1:0]       wb_data_i
);

  logic [XLEN-1:0] rf_a;
  logic [XLEN-1:0] rf_b;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] op_b;
  logic            fwd_a;
  logic            fwd_b;

  regfile u_regfile (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .raddr_a_i ( rs1_i     ),
    .raddr_b_i ( rs2_i     ),
    .rdata_a_o ( rf_a      ),
    .rdata_b_o ( rf_b      ),
    .we_i      ( wb_en_i   ),
    .waddr_i   ( wb_rd_i   ),
    .wdata_i   ( wb_data_i )
  );

  // ----------------------------------------
  // operand forwarding from commit
  // ----------------------------------------
  // commit still holds a result the regfile has not seen yet
  assign fwd_a = cm_valid_i && (cm_rd_i == rs1_i) && (rs1_i != '0);
  assign fwd_b = cm_valid_i && (cm_rd_i == rs2_i) && (rs2_i != '0);

  assign op_a    = fwd_a ? cm_result_i : rf_a;
  assign rs2_val = fwd_b ? cm_result_i : rf_b;
  assign op_b    = use_imm_i ? imm_i : rs2_val;

  alu u_alu (
    .op_i     ( alu_op_i     ),
    .a_i      ( op_a         ),
    .b_i      ( op_b         ),
    .result_o ( iss_result_o )
  );

  // no storage here, the item passes straight on to commit
  assign iss_valid_o   = dec_valid_i;
  assign dec_ready_o   = iss_ready_i;
  assign iss_rd_o      = rd_i;
  assign iss_illegal_o = illegal_i;
  assign iss_tval_o    = tval_i;

endmodule

`default_nettype wire

// File: src/commit_stage.sv
`timescale 1ns/100ps
`default_nettype none

module commit_stage import core_pkg::*; (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  iss_valid_i,
  output logic                       iss_ready_o,
  input  wire logic [REG_ADDR_W-1:0] iss_rd_i,
  input  wire logic [XLEN-1:0]       iss_result_i,
  input  wire logic                  iss_illegal_i,
  input  wire logic [31:0]           iss_tval_i,
  output logic                       cm_valid_o,
  output logic [REG_ADDR_W-1:0]      cm_rd_o,
  output logic [XLEN-1:0]            cm_result_o,
  output logic                       wb_en_o,
  output logic [REG_ADDR_W-1:0]      wb_rd_o,
  output logic [XLEN-1:0]            wb_data_o,
  output logic                       commit_valid_o,
  input  wire logic                  commit_ready_i,
  output logic [REG_ADDR_W-1:0]      commit_rd_o,
  output logic [XLEN-1:0]            commit_wdata_o,
  output logic                       commit_illegal_o,
  output logic [31:0]                commit_tval_o,
  output logic                       retire_o,
  output logic                       retire_illegal_o
);

  logic                  valid_q;
  logic [REG_ADDR_W-1:0] rd_q;
  logic [XLEN-1:0]       result_q;
  logic                  illegal_q;
  logic [31:0]           tval_q;
  logic                  retire;

  assign retire      = valid_q & commit_ready_i;
  assign iss_ready_o = ~valid_q | commit_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (iss_valid_i && iss_ready_o) begin
      valid_q <= 1'b1;
    end else if (retire) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (iss_valid_i && iss_ready_o) begin
      rd_q      <= iss_rd_i;
      result_q  <= iss_result_i;
      illegal_q <= iss_illegal_i;
      tval_q    <= iss_tval_i;
    end
  end

  // ----------------------------------------
  // forwarding and write back
  // ----------------------------------------
  assign cm_valid_o  = valid_q & ~illegal_q;
  assign cm_rd_o     = rd_q;
  assign cm_result_o = result_q;

  assign wb_en_o   = retire & ~illegal_q & (rd_q != '0);
  assign wb_rd_o   = rd_q;
  assign wb_data_o = result_q;

  // commit port
  assign commit_valid_o   = valid_q;
  assign commit_rd_o      = rd_q;
  assign commit_wdata_o   = illegal_q ? '0 : result_q;
  assign commit_illegal_o = illegal_q;
  assign commit_tval_o    = tval_q;

  assign retire_o         = retire;
  assign retire_illegal_o = retire & illegal_q;

  // a stalled commit keeps its item on the port
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_o && !commit_ready_i |=> commit_valid_o &&
      $stable({commit_rd_o, commit_wdata_o, commit_illegal_o, commit_tval_o}));

endmodule

`default_nettype wire

// File: src/perf_counters.sv
`timescale 1ns/100ps
`default_nettype none

module perf_counters #(
  parameter int CountWidth = 32
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  retire_i,
  input  wire logic                  retire_illegal_i,
  output logic [CountWidth-1:0]      instret_o,
  output logic [CountWidth-1:0]      illegal_count_o
);

  // both counters stick at all ones
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instret_o       <= '0;
      illegal_count_o <= '0;
    end else begin
      if (retire_i && instret_o != '1) begin
        instret_o <= instret_o + 1'b1;
      end
      if (retire_illegal_i && illegal_count_o != '1) begin
        illegal_count_o <= illegal_count_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/core_top.sv
`timescale 1ns/100ps
`default_nettype none

module core_top import core_pkg::*; #(
  parameter int CountWidth = 32
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  instr_valid_i,
  output logic                       instr_ready_o,
  input  wire logic [31:0]           instr_i,
  output logic                       commit_valid_o,
  input  wire logic                  commit_ready_i,
  output logic [REG_ADDR_W-1:0]      commit_rd_o,
  output logic [XLEN-1:0]            commit_wdata_o,
  output logic                       commit_illegal_o,
  output logic [31:0]                commit_tval_o,
  output logic [CountWidth-1:0]      instret_o,
  output logic [CountWidth-1:0]      illegal_count_o
);

  // ----------------------------------------
  // decode to issue
  // ----------------------------------------
  logic                  dec_valid;
  logic                  dec_ready;
  logic [REG_ADDR_W-1:0] dec_rs1;
  logic [REG_ADDR_W-1:0] dec_rs2;
  logic [REG_ADDR_W-1:0] dec_rd;
  logic [XLEN-1:0]       dec_imm;
  logic                  dec_use_imm;
  logic [ALU_OP_W-1:0]   dec_alu_op;
  logic                  dec_illegal;
  logic [31:0]           dec_tval;

  // issue to commit
  logic                  iss_valid;
  logic                  iss_ready;
  logic [REG_ADDR_W-1:0] iss_rd;
  logic [XLEN-1:0]       iss_result;
  logic                  iss_illegal;
  logic [31:0]           iss_tval;

  // commit back to issue
  logic                  cm_valid;
  logic [REG_ADDR_W-1:0] cm_rd;
  logic [XLEN-1:0]       cm_result;
  logic                  wb_en;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]       wb_data;

  logic                  retire;
  logic                  retire_illegal;

  id_stage u_id_stage (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .instr_valid_i ( instr_valid_i ),
    .instr_ready_o ( instr_ready_o ),
    .instr_i       ( instr_i       ),
    .dec_valid_o   ( dec_valid     ),
    .dec_ready_i   ( dec_ready     ),
    .rs1_o         ( dec_rs1       ),
    .rs2_o         ( dec_rs2       ),
    .rd_o          ( dec_rd        ),
    .imm_o         ( dec_imm       ),
    .use_imm_o     ( dec_use_imm   ),
    .alu_op_o      ( dec_alu_op    ),
    .illegal_o     ( dec_illegal   ),
    .tval_o        ( dec_tval      )
  );

  issue_stage u_issue_stage (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .dec_valid_i   ( dec_valid     ),
    .dec_ready_o   ( dec_ready     ),
    .rs1_i         ( dec_rs1       ),
    .rs2_i         ( dec_rs2       ),
    .rd_i          ( dec_rd        ),
    .imm_i         ( dec_imm       ),
    .use_imm_i     ( dec_use_imm   ),
    .alu_op_i      ( dec_alu_op    ),
    .illegal_i     ( dec_illegal   ),
    .tval_i        ( dec_tval      ),
    .iss_valid_o   ( iss_valid     ),
    .iss_ready_i   ( iss_ready     ),
    .iss_rd_o      ( iss_rd        ),
    .iss_result_o  ( iss_result    ),
    .iss_illegal_o ( iss_illegal   ),
    .iss_tval_o    ( iss_tval      ),
    .cm_valid_i    ( cm_valid      ),
    .cm_rd_i       ( cm_rd         ),
    .cm_result_i   ( cm_result     ),
    .wb_en_i       ( wb_en         ),
    .wb_rd_i       ( wb_rd         ),
    .wb_data_i     ( wb_data       )
  );

  commit_stage u_commit_stage (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .iss_valid_i      ( iss_valid        ),
    .iss_ready_o      ( iss_ready        ),
    .iss_rd_i         ( iss_rd           ),
    .iss_result_i     ( iss_result       ),
    .iss_illegal_i    ( iss_illegal      ),
    .iss_tval_i       ( iss_tval         ),
    .cm_valid_o       ( cm_valid         ),
    .cm_rd_o          ( cm_rd            ),
    .cm_result_o      ( cm_result        ),
    .wb_en_o          ( wb_en            ),
    .wb_rd_o          ( wb_rd            ),
    .wb_data_o        ( wb_data          ),
    .commit_valid_o   ( commit_valid_o   ),
    .commit_ready_i   ( commit_ready_i   ),
    .commit_rd_o      ( commit_rd_o      ),
    .commit_wdata_o   ( commit_wdata_o   ),
    .commit_illegal_o ( commit_illegal_o ),
    .commit_tval_o    ( commit_tval_o    ),
    .retire_o         ( retire           ),
    .retire_illegal_o ( retire_illegal   )
  );

  perf_counters #(
    .CountWidth ( CountWidth )
  ) u_perf_counters (
    .clk_i            ( clk_i           ),
    .rst_ni           ( rst_ni          ),
    .retire_i         ( retire          ),
    .retire_illegal_i ( retire_illegal  ),
    .instret_o        ( instret_o       ),
    .illegal_count_o  ( illegal_count_o )
  );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
  parameter int HalfPeriodNs = 4
) (
  output logic clk_o
);

  // free running, 8 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #(HalfPeriodNs);
      clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_checker (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire logic        instr_ready_i,
  input  wire logic        commit_valid_i,
  output logic             commit_ready_o,
  input  wire logic [4:0]  commit_rd_i,
  input  wire logic [31:0] commit_wdata_i,
  input  wire logic        commit_illegal_i,
  input  wire logic [31:0] commit_tval_i,
  input  wire logic [31:0] instret_i,
  input  wire logic [31:0] illegal_count_i,
  output int               commit_count_o,
  output int               error_count_o
);

  // rows in flight, oldest first
  string       exp_name_q[$];
  logic [4:0]  exp_rd_q[$];
  logic [31:0] exp_wdata_q[$];
  logic        exp_illegal_q[$];
  logic [31:0] exp_tval_q[$];

  initial begin
    commit_ready_o = 1'b0;
    commit_count_o = 0;
    error_count_o  = 0;
  end

  // random back-pressure, ready three cycles out of four on average
  always @(posedge clk_i) begin
    #1;
    commit_ready_o = ($urandom_range(0, 3) != 0);
  end

  task automatic expect_row(input string name, input logic [4:0] rd,
                            input logic [31:0] wdata, input logic illegal,
                            input logic [31:0] word);
    exp_name_q.push_back(name);
    exp_rd_q.push_back(rd);
    exp_wdata_q.push_back(wdata);
    exp_illegal_q.push_back(illegal);
    exp_tval_q.push_back(word);
  endtask

  task automatic report_mismatch(input string name, input string field,
                                 input logic [31:0] exp, input logic [31:0] act);
    error_count_o++;
    $display("error: %s %s expected %h actual %h", name, field, exp, act);
  endtask

  // ----------------------------------------
  // commit port
  // ----------------------------------------
  task automatic compare_commit();
    string       name;
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic        illegal;
    logic [31:0] tval;
    if (exp_name_q.size() == 0) begin
      error_count_o++;
      $display("a commit arrived with no row left to match it, tval %h", commit_tval_i);
    end else begin
      name    = exp_name_q.pop_front();
      rd      = exp_rd_q.pop_front();
      wdata   = exp_wdata_q.pop_front();
      illegal = exp_illegal_q.pop_front();
      tval    = exp_tval_q.pop_front();
      commit_count_o++;
      if (commit_illegal_i !== illegal) begin
        report_mismatch(name, "illegal", {31'd0, illegal}, {31'd0, commit_illegal_i});
      end
      if (commit_wdata_i !== wdata) begin
        report_mismatch(name, "wdata", wdata, commit_wdata_i);
      end
      // an exception names no destination
      if (!illegal && commit_rd_i !== rd) begin
        report_mismatch(name, "rd", {27'd0, rd}, {27'd0, commit_rd_i});
      end
      if (illegal && commit_tval_i !== tval) begin
        report_mismatch(name, "tval", tval, commit_tval_i);
      end
    end
  endtask

  // handshake decided at the next rising edge, inputs are stable here
  always @(negedge clk_i) begin
    if (rst_ni && commit_valid_i && commit_ready_o) begin
      compare_commit();
    end
  end

  task automatic check_reset_state();
    if (instr_ready_i !== 1'b1) begin
      report_mismatch("reset", "instr_ready", 32'd1, {31'd0, instr_ready_i});
    end
    if (commit_valid_i !== 1'b0) begin
      report_mismatch("reset", "commit_valid", 32'd0, {31'd0, commit_valid_i});
    end
    if (instret_i !== 32'd0) begin
      report_mismatch("reset", "instret", 32'd0, instret_i);
    end
    if (illegal_count_i !== 32'd0) begin
      report_mismatch("reset", "illegal_count", 32'd0, illegal_count_i);
    end
  endtask

  // ----------------------------------------
  // end of run
  // ----------------------------------------
  task automatic check_counters(input int exp_retired, input int exp_illegal);
    if (instret_i !== exp_retired) begin
      report_mismatch("counters", "instret", exp_retired, instret_i);
    end
    if (illegal_count_i !== exp_illegal) begin
      report_mismatch("counters", "illegal_count", exp_illegal, illegal_count_i);
    end
    if (commit_valid_i !== 1'b0) begin
      report_mismatch("drained", "commit_valid", 32'd0, {31'd0, commit_valid_i});
    end
    if (exp_name_q.size() != 0) begin
      error_count_o++;
      $display("%0d rows never reached the commit port", exp_name_q.size());
    end
  endtask

endmodule

`default_nettype wire

// File: tests/tb_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_top import core_pkg::*; ();

  localparam int MaxRows    = 32;
  localparam int ReadyLimit = 200;
  localparam int DrainLimit = 400;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic        instr_ready;
  logic [31:0] instr;
  logic        commit_valid;
  logic        commit_ready;
  logic [4:0]  commit_rd;
  logic [31:0] commit_wdata;
  logic        commit_illegal;
  logic [31:0] commit_tval;
  logic [31:0] instret;
  logic [31:0] illegal_count;
  int          commit_count;
  int          check_errors;
  int          timeouts;

  // stimulus table
  string       name_tab[MaxRows];
  logic [31:0] instr_tab[MaxRows];
  logic [4:0]  rd_tab[MaxRows];
  logic [31:0] wdata_tab[MaxRows];
  logic        illegal_tab[MaxRows];
  int          row_count;
  int          illegal_rows;

  tb_clock u_clock (
    .clk_o ( clk )
  );

  core_top #(
    .CountWidth ( 32 )
  ) u_dut (
    .clk_i            ( clk            ),
    .rst_ni           ( rst_n          ),
    .instr_valid_i    ( instr_valid    ),
    .instr_ready_o    ( instr_ready    ),
    .instr_i          ( instr          ),
    .commit_valid_o   ( commit_valid   ),
    .commit_ready_i   ( commit_ready   ),
    .commit_rd_o      ( commit_rd      ),
    .commit_wdata_o   ( commit_wdata   ),
    .commit_illegal_o ( commit_illegal ),
    .commit_tval_o    ( commit_tval    ),
    .instret_o        ( instret        ),
    .illegal_count_o  ( illegal_count  )
  );

  tb_checker u_checker (
    .clk_i            ( clk            ),
    .rst_ni           ( rst_n          ),
    .instr_ready_i    ( instr_ready    ),
    .commit_valid_i   ( commit_valid   ),
    .commit_ready_o   ( commit_ready   ),
    .commit_rd_i      ( commit_rd      ),
    .commit_wdata_i   ( commit_wdata   ),
    .commit_illegal_i ( commit_illegal ),
    .commit_tval_i    ( commit_tval    ),
    .instret_i        ( instret        ),
    .illegal_count_i  ( illegal_count  ),
    .commit_count_o   ( commit_count   ),
    .error_count_o    ( check_errors   )
  );

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                        input logic [2:0] f3, input int rd);
    instr_t w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2[4:0];
    w.r.rs1    = rs1[4:0];
    w.r.funct3 = f3;
    w.r.rd     = rd[4:0];
    w.r.opcode = OPC_OP;
    return w;
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1,
                                        input logic [2:0] f3, input int rd,
                                        input logic [6:0] opc);
    instr_t w;
    w.i.imm    = imm;
    w.i.rs1    = rs1[4:0];
    w.i.funct3 = f3;
    w.i.rd     = rd[4:0];
    w.i.opcode = opc;
    return w;
  endfunction

  task automatic add_row(input string name, input logic [31:0] word, input int rd,
                         input logic [31:0] wdata, input logic illegal);
    name_tab[row_count]    = name;
    instr_tab[row_count]   = word;
    rd_tab[row_count]      = rd[4:0];
    wdata_tab[row_count]   = wdata;
    illegal_tab[row_count] = illegal;
    row_count++;
    if (illegal) begin
      illegal_rows++;
    end
  endtask

  // ----------------------------------------
  // rows, results worked out by hand
  // ----------------------------------------
  task automatic fill_table();
    add_row("addi_pos", enc_i(12'h005, 0, F3_ADD_SUB, 1, OPC_OP_IMM), 1, 32'h0000_0005, 1'b0);
    add_row("addi_neg", enc_i(12'hffd, 0, F3_ADD_SUB, 2, OPC_OP_IMM), 2, 32'hffff_fffd, 1'b0);
    add_row("addi_max", enc_i(12'h7ff, 0, F3_ADD_SUB, 3, OPC_OP_IMM), 3, 32'h0000_07ff, 1'b0);
    add_row("addi_min", enc_i(12'h800, 0, F3_ADD_SUB, 4, OPC_OP_IMM), 4, 32'hffff_f800, 1'b0);
    add_row("add_mixed", enc_r(F7_BASE, 2, 1, F3_ADD_SUB, 5), 5, 32'h0000_0002, 1'b0);
    // 2 - 5 right behind the producer of x5
    add_row("sub_dep", enc_r(F7_SUB, 1, 5, F3_ADD_SUB, 6), 6, 32'hffff_fffd, 1'b0);
    add_row("and_dep", enc_r(F7_BASE, 3, 6, F3_AND, 7), 7, 32'h0000_07fd, 1'b0);
    add_row("or_sign", enc_r(F7_BASE, 4, 1, F3_OR, 8), 8, 32'hffff_f805, 1'b0);
    add_row("xor_dep", enc_r(F7_BASE, 2, 8, F3_XOR, 9), 9, 32'h0000_07f8, 1'b0);
    add_row("add_wrap", enc_r(F7_BASE, 4, 4, F3_ADD_SUB, 10), 10, 32'hffff_f000, 1'b0);
    add_row("andi_dep", enc_i(12'h0f0, 9, F3_AND, 11, OPC_OP_IMM), 11, 32'h0000_00f0, 1'b0);
    add_row("ori_neg", enc_i(12'hff0, 11, F3_OR, 12, OPC_OP_IMM), 12, 32'hffff_fff0, 1'b0);
    add_row("xori_not", enc_i(12'hfff, 12, F3_XOR, 13, OPC_OP_IMM), 13, 32'h0000_000f, 1'b0);
    // result of 5 + 9 shows on the port but x0 keeps zero
    add_row("addi_x0", enc_i(12'h009, 1, F3_ADD_SUB, 0, OPC_OP_IMM), 0, 32'h0000_000e, 1'b0);
    add_row("xor_read_x0", enc_r(F7_BASE, 13, 0, F3_XOR, 14), 14, 32'h0000_000f, 1'b0);
    add_row("mul_illegal", enc_r(7'b0000001, 2, 1, F3_ADD_SUB, 5), 0, 32'h0, 1'b1);
    add_row("add_after_mul", enc_r(F7_BASE, 0, 5, F3_ADD_SUB, 15), 15, 32'h0000_0002, 1'b0);
    add_row("load_illegal", enc_i(12'h000, 1, 3'b010, 6, 7'b0000011), 0, 32'h0, 1'b1);
    add_row("slli_illegal", enc_i(12'h001, 1, 3'b001, 7, OPC_OP_IMM), 0, 32'h0, 1'b1);
    add_row("or_after_ill", enc_r(F7_BASE, 7, 6, F3_OR, 16), 16, 32'hffff_fffd, 1'b0);
    add_row("sub_self", enc_r(F7_SUB, 16, 16, F3_ADD_SUB, 17), 17, 32'h0000_0000, 1'b0);
    add_row("addi_dep_neg", enc_i(12'hfff, 17, F3_ADD_SUB, 17, OPC_OP_IMM), 17,
            32'hffff_ffff, 1'b0);
  endtask

  // called 1 ns after a rising edge, returns at the same offset
  task automatic send_instr(input logic [31:0] word, output bit taken);
    int waited;
    waited = 0;
    taken  = 1'b0;
    instr_valid = 1'b1;
    instr       = word;
    while (!taken && waited < ReadyLimit) begin
      @(negedge clk);
      taken = instr_ready;
      @(posedge clk);
      #1;
      waited++;
    end
    instr_valid = 1'b0;
    instr       = '0;
  endtask

  task automatic wait_for_commits(input int count, output bit done);
    int waited;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < DrainLimit) begin
      @(negedge clk);
      done = (commit_count >= count);
      waited++;
    end
  endtask

  initial begin
    bit ok;
    int idle;
    void'($urandom(32'he61b_1964));
    rst_n        = 1'b0;
    instr_valid  = 1'b0;
    instr        = '0;
    timeouts     = 0;
    row_count    = 0;
    illegal_rows = 0;
    fill_table();

    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    u_checker.check_reset_state();
    @(posedge clk);
    #1;

    ok = 1'b1;
    for (int r = 0; r < row_count && ok; r++) begin
      // mostly back to back so dependent rows meet in issue and commit
      if ($urandom_range(0, 3) == 0) begin
        idle = $urandom_range(1, 3);
      end else begin
        idle = 0;
      end
      repeat (idle) begin
        @(posedge clk);
        #1;
      end
      u_checker.expect_row(name_tab[r], rd_tab[r], wdata_tab[r], illegal_tab[r],
                           instr_tab[r]);
      send_instr(instr_tab[r], ok);
      if (!ok) begin
        timeouts++;
        $display("timeout: row %s was not accepted within %0d cycles", name_tab[r],
                 ReadyLimit);
      end
    end

    if (ok) begin
      wait_for_commits(row_count, ok);
      if (!ok) begin
        timeouts++;
        $display("timeout: only %0d of %0d rows committed within %0d cycles",
                 commit_count, row_count, DrainLimit);
      end
    end
    if (ok) begin
      repeat (4) @(negedge clk);
      u_checker.check_counters(row_count, illegal_rows);
    end

    $display("rows %0d, commits %0d, check errors %0d, timeouts %0d",
             row_count, commit_count, check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
src/core_pkg.sv
src/alu.sv
src/regfile.sv
src/id_stage.sv
src/issue_stage.sv
src/commit_stage.sv
src/perf_counters.sv
src/core_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: Makefile
# Verilator build and run of the core testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -f tb.f --top-module tb_top -Mdir obj_dir
	./obj_dir/Vtb_top > sim.log 2>&1; cat sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@if ! grep -q "test passed" sim.log; then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
